// ==== hdl/io_schedule_pkg.sv ====
`default_nettype none

package io_schedule_pkg;

	// bus and command widths
	localparam int COMMAND_WIDTH = 128;
	localparam int GC_COMMAND_WIDTH = 29;
	localparam int PADDR_WIDTH = 27;
	localparam int LADDR_WIDTH = 28;
	localparam int DRAM_ADDR_WIDTH = 28;
	localparam int DRAM_IO_WIDTH = 256;
	localparam int NUM_CHANNELS = 8;
	localparam int SLOT_WIDTH = 19;
	localparam int CHAN_WIDTH = $clog2(NUM_CHANNELS);

	// host and gc command fields
	localparam int OPCODE_MSB = 127;
	localparam int OPCODE_LSB = 126;
	localparam int CACHE_SEL_BIT = 125;
	localparam int SLOT_LSB = 32;
	localparam int GC_ERASE_BIT = 28;
	// channel sits above the 24-bit in-channel address
	localparam int CHAN_LSB = 24;

	localparam logic [1:0] OP_READ = 2'b00;
	localparam logic [1:0] OP_WRITE = 2'b01;
	localparam logic [1:0] OP_MOVE = 2'b10;
	localparam logic [1:0] OP_ERASE = 2'b11;

	// write cache regions in dram
	localparam logic [DRAM_ADDR_WIDTH-1:0] CACHE_BASE = 28'h010_0000;
	localparam logic [DRAM_ADDR_WIDTH-1:0] ADDITIONAL_CACHE_BASE = 28'h800_0000;
	localparam int SLOT_SHIFT = 9;
	localparam int DRAM_ADDR_STEP = 8;

	// write burst and back-off sizes
	localparam int BURST_REQUESTS = 4;
	localparam int BEATS_PER_REQUEST = 2;
	localparam int BACKOFF_CYCLES = 64;
	localparam int REQ_CNT_WIDTH = $clog2(BURST_REQUESTS) + 1;
	localparam int BEAT_CNT_WIDTH = $clog2(BURST_REQUESTS * BEATS_PER_REQUEST);
	localparam int BACKOFF_CNT_WIDTH = $clog2(BACKOFF_CYCLES);

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_READ,
		KIND_WRITE,
		KIND_MOVE,
		KIND_ERASE
	} cmd_kind_t;

endpackage

`default_nettype wire

// ==== hdl/io_schedule_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// physical address request toward the lookup master
interface lookup_if;
	import io_schedule_pkg::*;

	logic start;
	logic done;
	cmd_kind_t kind;
	logic [LADDR_WIDTH-1:0] laddr;
	logic [PADDR_WIDTH-1:0] paddr0;
	logic [PADDR_WIDTH-1:0] paddr1;

	modport ctrl (output start, input done);
	modport fmt (output kind, laddr, input done, paddr0, paddr1);
	modport port (input start, kind, laddr, output done, paddr0, paddr1);
endinterface

// write data fetch from the dram cache
interface fetch_if;
	import io_schedule_pkg::*;

	logic start;
	logic cache_sel;
	logic [SLOT_WIDTH-1:0] slot;
	logic done;

	modport ctrl (output start, input done);
	modport fmt (output cache_sel, slot);
	modport fetch (input start, cache_sel, slot, output done);
endinterface

`default_nettype wire

// ==== hdl/sched_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module sched_ctrl (
	input wire clk,
	input wire reset,
	input wire ssd_command_fifo_empty_or_not,
	input wire gc_command_fifo_empty_or_not,
	input wire dram_permit,
	input wire io_schedule_pkg::cmd_kind_t kind,
	input wire chan_ok,
	input wire all_free,
	output logic ssd_command_fifo_out_en,
	output logic gc_command_fifo_out_en,
	output logic load_host,
	output logic load_gc,
	output logic dram_request,
	output logic release_dram,
	output logic check,
	output logic send,
	lookup_if.ctrl lookup,
	fetch_if.ctrl fetch
);
	import io_schedule_pkg::*;

	typedef enum logic [3:0] {
		IDLE, TAKE_HOST, TAKE_GC, LOCK, DECODE, LOOKUP, CHECK, CHECK_WAIT,
		SEND, SENT, FETCH, FETCH_WAIT, BACKOFF_REL, BACKOFF_WAIT, UNLOCK
	} state_t;

	state_t state;
	// where the lock wait resumes once dram is granted
	state_t return_state;
	logic [BACKOFF_CNT_WIDTH-1:0] backoff_cnt;

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= IDLE;
			return_state <= DECODE;
			backoff_cnt <= '0;
		end
		else
		begin
			case (state)
				// host only when every channel can take a command
				IDLE:
				begin
					if (!ssd_command_fifo_empty_or_not && all_free)
						state <= TAKE_HOST;
					else if (!gc_command_fifo_empty_or_not)
						state <= TAKE_GC;
				end
				TAKE_HOST, TAKE_GC:
				begin
					return_state <= DECODE;
					state <= LOCK;
				end
				LOCK:
				begin
					if (dram_permit)
						state <= return_state;
				end
				// unknown opcode is dropped
				DECODE:
					state <= (kind == KIND_NONE) ? UNLOCK : LOOKUP;
				LOOKUP:
				begin
					if (lookup.done)
						state <= CHECK;
				end
				CHECK:
					state <= CHECK_WAIT;
				CHECK_WAIT:
					state <= chan_ok ? SEND : BACKOFF_REL;
				SEND:
					state <= SENT;
				SENT:
					state <= (kind == KIND_WRITE) ? FETCH : UNLOCK;
				FETCH:
					state <= FETCH_WAIT;
				FETCH_WAIT:
				begin
					if (fetch.done)
						state <= UNLOCK;
				end
				//////////////////////////////////////////////////////////////////////
				// channel busy, give dram away for a while
				BACKOFF_REL:
				begin
					backoff_cnt <= '0;
					state <= BACKOFF_WAIT;
				end
				BACKOFF_WAIT:
				begin
					backoff_cnt <= backoff_cnt + 1'b1;
					if (backoff_cnt == BACKOFF_CNT_WIDTH'(BACKOFF_CYCLES - 2))
					begin
						return_state <= CHECK;
						state <= LOCK;
					end
				end
				UNLOCK:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// strobes decoded from state
	assign ssd_command_fifo_out_en = (state == TAKE_HOST);
	assign load_host = (state == TAKE_HOST);
	assign gc_command_fifo_out_en = (state == TAKE_GC);
	assign load_gc = (state == TAKE_GC);
	assign dram_request = (state == LOCK);
	assign release_dram = (state == BACKOFF_REL) || (state == UNLOCK);
	assign check = (state == CHECK);
	assign send = (state == SEND);
	assign lookup.start = (state == DECODE) && (kind != KIND_NONE);
	assign fetch.start = (state == FETCH);

endmodule

`default_nettype wire

// ==== hdl/cmd_format.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_format (
	input wire clk,
	input wire reset,
	input wire load_host,
	input wire load_gc,
	input wire [io_schedule_pkg::COMMAND_WIDTH-1:0] ssd_command_fifo_out,
	input wire [io_schedule_pkg::GC_COMMAND_WIDTH-1:0] gc_command_fifo_out,
	output io_schedule_pkg::cmd_kind_t kind,
	output logic [io_schedule_pkg::CHAN_WIDTH-1:0] channel,
	output logic [io_schedule_pkg::COMMAND_WIDTH-1:0] controller_command,
	lookup_if.fmt lookup,
	fetch_if.fmt fetch
);
	import io_schedule_pkg::*;

	logic [COMMAND_WIDTH-1:0] host_cmd;
	logic [GC_COMMAND_WIDTH-1:0] gc_cmd;
	logic [PADDR_WIDTH-1:0] paddr0;
	logic [PADDR_WIDTH-1:0] paddr1;

	always_ff @(posedge clk)
	begin
		if (load_host)
			host_cmd <= ssd_command_fifo_out;
		if (load_gc)
			gc_cmd <= gc_command_fifo_out;
		if (lookup.done)
		begin
			paddr0 <= lookup.paddr0;
			paddr1 <= lookup.paddr1;
		end
	end

	// kind fixed at intake
	always_ff @(posedge clk)
	begin
		if (!reset)
			kind <= KIND_NONE;
		else if (load_host)
		begin
			case (ssd_command_fifo_out[OPCODE_MSB:OPCODE_LSB])
				OP_READ: kind <= KIND_READ;
				OP_WRITE: kind <= KIND_WRITE;
				default: kind <= KIND_NONE;
			endcase
		end
		else if (load_gc)
			kind <= gc_command_fifo_out[GC_ERASE_BIT] ? KIND_ERASE : KIND_MOVE;
	end

	assign lookup.kind = kind;
	assign lookup.laddr = (kind == KIND_MOVE || kind == KIND_ERASE) ?
		gc_cmd[LADDR_WIDTH-1:0] : host_cmd[LADDR_WIDTH-1:0];
	assign fetch.cache_sel = host_cmd[CACHE_SEL_BIT];
	assign fetch.slot = host_cmd[SLOT_LSB +: SLOT_WIDTH];

	// erase targets the gc block address directly
	assign channel = (kind == KIND_ERASE) ?
		gc_cmd[CHAN_LSB +: CHAN_WIDTH] : paddr0[CHAN_LSB +: CHAN_WIDTH];

	always_comb
	begin
		case (kind)
			KIND_READ: controller_command = {host_cmd[COMMAND_WIDTH-1:89], 1'b0,
				paddr0[23:0], host_cmd[63:0]};
			KIND_WRITE: controller_command = {OP_WRITE, host_cmd[CACHE_SEL_BIT], 37'b0,
				paddr0[23:0], host_cmd[63:0]};
			// target above source
			KIND_MOVE: controller_command = {OP_MOVE, 71'b0, paddr1[24:0], 5'b0,
				paddr0[24:0]};
			KIND_ERASE: controller_command = {OP_ERASE, 99'b0, gc_cmd[26:0]};
			default: controller_command = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/chan_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module chan_select (
	input wire clk,
	input wire reset,
	input wire [io_schedule_pkg::CHAN_WIDTH-1:0] channel,
	input wire [io_schedule_pkg::NUM_CHANNELS-1:0] command_available,
	input wire check,
	input wire send,
	input wire [io_schedule_pkg::COMMAND_WIDTH-1:0] controller_command,
	output logic chan_ok,
	output logic all_free,
	output logic [io_schedule_pkg::COMMAND_WIDTH-1:0] controller_command_fifo_in,
	output logic [io_schedule_pkg::NUM_CHANNELS-1:0] controller_command_fifo_in_en,
	output logic [io_schedule_pkg::NUM_CHANNELS-1:0] enable
);
	import io_schedule_pkg::*;

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			enable <= '0;
			chan_ok <= 1'b0;
			controller_command_fifo_in_en <= '0;
		end
		else
		begin
			// one-hot select and availability sampled together
			if (check)
			begin
				enable <= NUM_CHANNELS'(1) << channel;
				chan_ok <= command_available[channel];
			end
			controller_command_fifo_in_en <= send ? enable : '0;
		end
	end

	// word stays on the bus until the next send
	always_ff @(posedge clk)
	begin
		if (send)
			controller_command_fifo_in <= controller_command;
	end

	assign all_free = &command_available;

endmodule

`default_nettype wire

// ==== hdl/addr_lookup.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_lookup (
	input wire clk,
	input wire reset,
	input wire addr_ack,
	input wire [io_schedule_pkg::PADDR_WIDTH-1:0] addr_paddr0,
	input wire [io_schedule_pkg::PADDR_WIDTH-1:0] addr_paddr1,
	output logic addr_req,
	output logic [1:0] addr_op,
	output logic [io_schedule_pkg::LADDR_WIDTH-1:0] addr_laddr,
	lookup_if.port lookup
);
	import io_schedule_pkg::*;

	typedef enum logic [1:0] {L_IDLE, L_REQ, L_ACK_LOW} lk_state_t;

	lk_state_t state;

	//////////////////////////////////////////////////////////////////////
	// four-phase master
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= L_IDLE;
			addr_req <= 1'b0;
			lookup.done <= 1'b0;
		end
		else
		begin
			lookup.done <= 1'b0;
			case (state)
				L_IDLE:
				begin
					if (lookup.start)
					begin
						addr_req <= 1'b1;
						state <= L_REQ;
					end
				end
				L_REQ:
				begin
					if (addr_ack)
					begin
						addr_req <= 1'b0;
						state <= L_ACK_LOW;
					end
				end
				// responder must drop ack before the next request
				L_ACK_LOW:
				begin
					if (!addr_ack)
					begin
						lookup.done <= 1'b1;
						state <= L_IDLE;
					end
				end
				default:
					state <= L_IDLE;
			endcase
		end
	end

	// request fields and returned addresses
	always_ff @(posedge clk)
	begin
		if (state == L_IDLE && lookup.start)
		begin
			addr_laddr <= lookup.laddr;
			case (lookup.kind)
				KIND_WRITE: addr_op <= OP_WRITE;
				KIND_MOVE: addr_op <= OP_MOVE;
				KIND_ERASE: addr_op <= OP_ERASE;
				default: addr_op <= OP_READ;
			endcase
		end
		if (state == L_REQ && addr_ack)
		begin
			lookup.paddr0 <= addr_paddr0;
			lookup.paddr1 <= addr_paddr1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/wdata_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module wdata_fetch (
	input wire clk,
	input wire reset,
	input wire dram_ready,
	input wire rd_data_valid,
	input wire [io_schedule_pkg::DRAM_IO_WIDTH-1:0] data_from_dram,
	input wire [io_schedule_pkg::NUM_CHANNELS-1:0] enable,
	output logic dram_en,
	output logic [io_schedule_pkg::DRAM_ADDR_WIDTH-1:0] addr_to_dram,
	output logic [io_schedule_pkg::DRAM_IO_WIDTH-1:0] write_data_fifo_in,
	output logic [io_schedule_pkg::NUM_CHANNELS-1:0] write_data_fifo_in_en,
	fetch_if.fetch fetch
);
	import io_schedule_pkg::*;

	logic busy;
	logic [REQ_CNT_WIDTH-1:0] req_cnt;
	logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
	logic [DRAM_ADDR_WIDTH-1:0] start_addr;

	// slot offset into main or additional cache
	assign start_addr = (fetch.cache_sel ? CACHE_BASE : ADDITIONAL_CACHE_BASE) +
		(DRAM_ADDR_WIDTH'(fetch.slot) << SLOT_SHIFT);

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			busy <= 1'b0;
			dram_en <= 1'b0;
			req_cnt <= '0;
			beat_cnt <= '0;
			fetch.done <= 1'b0;
			write_data_fifo_in_en <= '0;
		end
		else
		begin
			fetch.done <= 1'b0;
			write_data_fifo_in_en <= '0;
			if (fetch.start)
			begin
				busy <= 1'b1;
				req_cnt <= '0;
				beat_cnt <= '0;
			end
			else if (busy)
			begin
				// one idle cycle between requests
				if (dram_en && dram_ready)
				begin
					dram_en <= 1'b0;
					req_cnt <= req_cnt + 1'b1;
				end
				else if (!dram_en && req_cnt != REQ_CNT_WIDTH'(BURST_REQUESTS))
					dram_en <= 1'b1;
				// beats counted apart from requests
				if (rd_data_valid)
				begin
					write_data_fifo_in_en <= enable;
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == BEAT_CNT_WIDTH'(BURST_REQUESTS * BEATS_PER_REQUEST - 1))
					begin
						busy <= 1'b0;
						fetch.done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch.start)
			addr_to_dram <= start_addr;
		else if (dram_en && dram_ready)
			addr_to_dram <= addr_to_dram + DRAM_ADDR_WIDTH'(DRAM_ADDR_STEP);
		if (rd_data_valid)
			write_data_fifo_in <= data_from_dram;
	end

endmodule

`default_nettype wire

// ==== hdl/io_schedule.sv ====
`timescale 1ns/10ps
`default_nettype none

module io_schedule (
	input wire clk,
	input wire reset,
	input wire ssd_command_fifo_empty_or_not,
	input wire [io_schedule_pkg::COMMAND_WIDTH-1:0] ssd_command_fifo_out,
	output wire ssd_command_fifo_out_en,
	input wire gc_command_fifo_empty_or_not,
	input wire [io_schedule_pkg::GC_COMMAND_WIDTH-1:0] gc_command_fifo_out,
	output wire gc_command_fifo_out_en,
	input wire [io_schedule_pkg::NUM_CHANNELS-1:0] command_available,
	output wire dram_request,
	input wire dram_permit,
	output wire release_dram,
	output wire dram_en,
	output wire [io_schedule_pkg::DRAM_ADDR_WIDTH-1:0] addr_to_dram,
	input wire dram_ready,
	input wire rd_data_valid,
	input wire [io_schedule_pkg::DRAM_IO_WIDTH-1:0] data_from_dram,
	output wire addr_req,
	output wire [1:0] addr_op,
	output wire [io_schedule_pkg::LADDR_WIDTH-1:0] addr_laddr,
	input wire addr_ack,
	input wire [io_schedule_pkg::PADDR_WIDTH-1:0] addr_paddr0,
	input wire [io_schedule_pkg::PADDR_WIDTH-1:0] addr_paddr1,
	output wire [io_schedule_pkg::COMMAND_WIDTH-1:0] controller_command_fifo_in,
	output wire [io_schedule_pkg::NUM_CHANNELS-1:0] controller_command_fifo_in_en,
	output wire [io_schedule_pkg::DRAM_IO_WIDTH-1:0] write_data_fifo_in,
	output wire [io_schedule_pkg::NUM_CHANNELS-1:0] write_data_fifo_in_en
);
	import io_schedule_pkg::*;

	// control to formatter and channel select
	wire load_host;
	wire load_gc;
	wire check;
	wire send;
	wire chan_ok;
	wire all_free;
	cmd_kind_t kind;
	wire [CHAN_WIDTH-1:0] channel;
	wire [COMMAND_WIDTH-1:0] controller_command;
	wire [NUM_CHANNELS-1:0] enable;

	lookup_if lookup ();
	fetch_if fetch ();

	sched_ctrl i_sched_ctrl (.*);

	cmd_format i_cmd_format (.*);

	chan_select i_chan_select (.*);

	addr_lookup i_addr_lookup (.*);

	wdata_fetch i_wdata_fetch (.*);

endmodule

`default_nettype wire

// ==== sim/tb_io_schedule.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_io_schedule;
	import io_schedule_pkg::*;

	localparam int MAX_LINES = 32;
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int BURST_BEATS = BURST_REQUESTS * BEATS_PER_REQUEST;

	logic clk = 1'b0;
	logic reset;
	logic ssd_command_fifo_empty_or_not;
	logic [COMMAND_WIDTH-1:0] ssd_command_fifo_out;
	logic gc_command_fifo_empty_or_not;
	logic [GC_COMMAND_WIDTH-1:0] gc_command_fifo_out;
	logic [NUM_CHANNELS-1:0] command_available;
	logic dram_permit;
	logic dram_ready;
	logic rd_data_valid;
	logic [DRAM_IO_WIDTH-1:0] data_from_dram;
	logic addr_ack;
	logic [PADDR_WIDTH-1:0] addr_paddr0;
	logic [PADDR_WIDTH-1:0] addr_paddr1;
	wire ssd_command_fifo_out_en;
	wire gc_command_fifo_out_en;
	wire dram_request;
	wire release_dram;
	wire dram_en;
	wire [DRAM_ADDR_WIDTH-1:0] addr_to_dram;
	wire addr_req;
	wire [1:0] addr_op;
	wire [LADDR_WIDTH-1:0] addr_laddr;
	wire [COMMAND_WIDTH-1:0] controller_command_fifo_in;
	wire [NUM_CHANNELS-1:0] controller_command_fifo_in_en;
	wire [DRAM_IO_WIDTH-1:0] write_data_fifo_in;
	wire [NUM_CHANNELS-1:0] write_data_fifo_in_en;

	// stimulus lines
	logic line_src [MAX_LINES];
	logic line_last [MAX_LINES];
	logic [7:0] line_avail [MAX_LINES];
	logic [COMMAND_WIDTH-1:0] line_cmd [MAX_LINES];
	logic [PADDR_WIDTH-1:0] line_p0 [MAX_LINES];
	logic [PADDR_WIDTH-1:0] line_p1 [MAX_LINES];
	logic [7:0] line_en [MAX_LINES];
	logic [COMMAND_WIDTH-1:0] line_exp [MAX_LINES];
	int n_lines = 0;

	// fifo, lock, lookup and dram models
	int host_q [$];
	int gc_q [$];
	logic [DRAM_ADDR_WIDTH-1:0] beat_addr_q [$];
	int beat_idx_q [$];
	logic [31:0] lfsr = 32'h007e_619f;
	logic [7:0] avail_r = '1;
	logic permit_r = 0, ack_r = 0, ready_r = 0, valid_r = 0;
	logic [DRAM_IO_WIDTH-1:0] data_r = '0;
	logic [PADDR_WIDTH-1:0] p0_r = '0, p1_r = '0;
	int lock_wait = -1, ack_wait = -1, ready_wait = -1, drop_wait = -1;
	logic prev_req = 0, prev_ack = 0, prev_dram_req = 0, prev_permit = 0;

	// per command tracking
	int cur = 0, next_line = 0, cycle = 0, completed = 0;
	int cmd_pulses, beats, backoffs, req_count, rel_cycle, pulse_cycle;
	logic busy = 0, in_backoff = 0, finished = 0;

	io_schedule i_io_schedule (.*);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// error reporting and helpers

	task automatic report_mismatch(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		$display("SIMULATION FAILED");
		$fatal(1, "value check failed");
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1, "check failed");
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = v | (int'(lfsr[0]) << i);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [1:0] expected_op(input int i);
		if (!line_src[i])
			return line_cmd[i][OPCODE_MSB:OPCODE_LSB];
		return line_cmd[i][GC_ERASE_BIT] ? OP_ERASE : OP_MOVE;
	endfunction

	function automatic logic is_write(input int i);
		return !line_src[i] && line_cmd[i][OPCODE_MSB:OPCODE_LSB] == OP_WRITE;
	endfunction

	// cache base plus slot offset, one step per request
	function automatic logic [DRAM_ADDR_WIDTH-1:0] request_addr(input int i, input int r);
		logic [DRAM_ADDR_WIDTH-1:0] base;
		base = line_cmd[i][CACHE_SEL_BIT] ? CACHE_BASE : ADDITIONAL_CACHE_BASE;
		return base + (DRAM_ADDR_WIDTH'(line_cmd[i][SLOT_LSB +: SLOT_WIDTH]) << SLOT_SHIFT)
			+ DRAM_ADDR_WIDTH'(r * DRAM_ADDR_STEP);
	endfunction

	function automatic logic [DRAM_IO_WIDTH-1:0] expected_beat(input int i, input int k);
		logic [DRAM_ADDR_WIDTH-1:0] addr;
		addr = request_addr(i, k / BEATS_PER_REQUEST);
		return DRAM_IO_WIDTH'(addr) * 2 + DRAM_IO_WIDTH'(k % BEATS_PER_REQUEST);
	endfunction

	task automatic load_stimulus();
		int fd;
		int count;
		string text;
		logic [3:0] src, last;
		logic [7:0] avail, en;
		logic [COMMAND_WIDTH-1:0] cmd, exp;
		logic [31:0] p0, p1;
		fd = $fopen("sim/io_schedule_stimulus.txt", "r");
		assert (fd != 0) else report_error("cannot open the stimulus file");
		while (!$feof(fd))
		begin
			text = "";
			void'($fgets(text, fd));
			if (text.len() > 0 && text.getc(0) != "#")
			begin
				count = $sscanf(text, "%h %h %h %h %h %h %h %h",
					src, last, avail, cmd, p0, p1, en, exp);
				if (count == 8 && n_lines < MAX_LINES)
				begin
					line_src[n_lines] = src[0];
					line_last[n_lines] = last[0];
					line_avail[n_lines] = avail;
					line_cmd[n_lines] = cmd;
					line_p0[n_lines] = p0[PADDR_WIDTH-1:0];
					line_p1[n_lines] = p1[PADDR_WIDTH-1:0];
					line_en[n_lines] = en;
					line_exp[n_lines] = exp;
					n_lines++;
				end
			end
		end
		$fclose(fd);
		assert (n_lines > 0) else report_error("stimulus file holds no commands");
	endtask

	task automatic start_command();
		busy = 1;
		cmd_pulses = 0;
		beats = 0;
		backoffs = 0;
		req_count = 0;
		in_backoff = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// sampled at the falling edge, models stepped here

	task automatic observe();
		int delay;
		logic busy_before;
		busy_before = busy;
		cycle++;
		assert (cycle < TIMEOUT_CYCLES) else report_error("run exceeded its cycle limit");
		if (!busy_before && !ssd_command_fifo_out_en && !gc_command_fifo_out_en)
			assert (!dram_request && !release_dram && !addr_req && !dram_en &&
				controller_command_fifo_in_en == 0 && write_data_fifo_in_en == 0)
				else report_error("control output active while idle");
		// intake priority
		if (ssd_command_fifo_out_en)
		begin
			assert (host_q.size() > 0 && command_available == 8'hff)
				else report_error("host command taken while not allowed");
			cur = host_q.pop_front();
			start_command();
		end
		if (gc_command_fifo_out_en)
		begin
			assert (gc_q.size() > 0) else report_error("gc command taken from an empty fifo");
			assert (!(host_q.size() > 0 && command_available == 8'hff))
				else report_error("gc command taken ahead of an eligible host command");
			cur = gc_q.pop_front();
			start_command();
		end
		// dram lock
		if (prev_dram_req && !dram_request)
			assert (prev_permit) else report_error("dram_request dropped without permit");
		if (!prev_dram_req && dram_request && in_backoff)
		begin
			assert (cycle - rel_cycle >= BACKOFF_CYCLES)
				else report_error("dram_request raised again before the back-off ended");
			in_backoff = 0;
		end
		if (permit_r)
			permit_r = 0;
		else if (dram_request)
		begin
			if (lock_wait < 0)
			begin
				draw_bits(2, delay);
				lock_wait = delay;
			end
			if (lock_wait == 0)
				permit_r = 1;
			lock_wait--;
		end
		// four-phase address handshake
		if (addr_req && !prev_req)
		begin
			assert (!addr_ack) else report_error("addr_req raised before addr_ack fell");
			assert (addr_op == expected_op(cur))
				else report_mismatch("addr_op", addr_op, expected_op(cur));
			assert (addr_laddr == line_cmd[cur][LADDR_WIDTH-1:0])
				else report_mismatch("addr_laddr", addr_laddr, line_cmd[cur][LADDR_WIDTH-1:0]);
		end
		if (prev_req && !addr_req)
			assert (prev_ack) else report_error("addr_req dropped before addr_ack rose");
		if (ack_r)
		begin
			// responder holds ack a while after the request falls
			if (!addr_req)
			begin
				if (drop_wait < 0)
				begin
					draw_bits(4, delay);
					drop_wait = delay;
				end
				if (drop_wait == 0)
					ack_r = 0;
				drop_wait--;
			end
		end
		else if (addr_req)
		begin
			if (ack_wait < 0)
			begin
				draw_bits(2, delay);
				ack_wait = delay;
			end
			if (ack_wait == 0)
			begin
				ack_r = 1;
				p0_r = line_p0[cur];
				p1_r = line_p1[cur];
			end
			ack_wait--;
		end
		// dram read requests, two beats each
		if (dram_en && dram_ready)
		begin
			assert (addr_to_dram == request_addr(cur, req_count))
				else report_mismatch("addr_to_dram", addr_to_dram, request_addr(cur, req_count));
			for (int b = 0; b < BEATS_PER_REQUEST; b++)
			begin
				beat_addr_q.push_back(addr_to_dram);
				beat_idx_q.push_back(b);
			end
			req_count++;
		end
		if (ready_r)
			ready_r = 0;
		else if (dram_en)
		begin
			if (ready_wait < 0)
			begin
				draw_bits(2, delay);
				ready_wait = delay;
			end
			if (ready_wait == 0)
				ready_r = 1;
			ready_wait--;
		end
		valid_r = 0;
		if (beat_addr_q.size() > 0)
		begin
			valid_r = 1;
			data_r = DRAM_IO_WIDTH'(beat_addr_q.pop_front()) * 2 +
				DRAM_IO_WIDTH'(beat_idx_q.pop_front());
		end
		// controller command
		if (controller_command_fifo_in_en != 0)
		begin
			assert (busy && cmd_pulses == 0) else report_error("unexpected command pulse");
			assert (controller_command_fifo_in_en == line_en[cur])
				else report_mismatch("controller_command_fifo_in_en",
					controller_command_fifo_in_en, line_en[cur]);
			assert (controller_command_fifo_in == line_exp[cur])
				else report_mismatch("controller_command_fifo_in",
					controller_command_fifo_in, line_exp[cur]);
			assert ((command_available & line_en[cur]) != 0)
				else report_error("command sent to an unavailable channel");
			if ((line_avail[cur] & line_en[cur]) == 0)
				assert (backoffs > 0) else report_error("busy channel sent without back-off");
			cmd_pulses++;
			pulse_cycle = cycle;
		end
		// write data beats
		if (write_data_fifo_in_en != 0)
		begin
			assert (busy && is_write(cur) && cmd_pulses == 1 && beats < BURST_BEATS)
				else report_error("unexpected write data beat");
			assert (write_data_fifo_in_en == line_en[cur])
				else report_mismatch("write_data_fifo_in_en", write_data_fifo_in_en,
					line_en[cur]);
			assert (write_data_fifo_in == expected_beat(cur, beats))
				else report_mismatch("write_data_fifo_in", write_data_fifo_in,
					expected_beat(cur, beats));
			beats++;
		end
		// release ends a command or starts a back-off
		if (release_dram)
		begin
			assert (busy) else report_error("release_dram pulsed while idle");
			avail_r = '1;
			if (cmd_pulses == 0)
			begin
				backoffs++;
				in_backoff = 1;
				rel_cycle = cycle;
			end
			else
			begin
				if (is_write(cur))
					assert (beats == BURST_BEATS)
						else report_mismatch("write beat count", beats, BURST_BEATS);
				else
					assert (cycle == pulse_cycle + 1)
						else report_error("release_dram not one cycle after the command");
				busy = 0;
				completed++;
			end
		end
		prev_req = addr_req;
		prev_ack = addr_ack;
		prev_dram_req = dram_request;
		prev_permit = dram_permit;
		// next group goes in once everything has drained
		if (!busy && host_q.size() == 0 && gc_q.size() == 0)
		begin
			if (next_line >= n_lines)
				finished = 1;
			while (next_line < n_lines && !finished)
			begin
				if (line_src[next_line])
					gc_q.push_back(next_line);
				else
					host_q.push_back(next_line);
				avail_r = line_avail[next_line];
				next_line++;
				if (line_last[next_line - 1])
					break;
			end
		end
	endtask

	task automatic drive_inputs();
		ssd_command_fifo_empty_or_not <= (host_q.size() == 0);
		ssd_command_fifo_out <= (host_q.size() > 0) ? line_cmd[host_q[0]] : '0;
		gc_command_fifo_empty_or_not <= (gc_q.size() == 0);
		gc_command_fifo_out <= (gc_q.size() > 0) ?
			line_cmd[gc_q[0]][GC_COMMAND_WIDTH-1:0] : '0;
		command_available <= avail_r;
		dram_permit <= permit_r;
		addr_ack <= ack_r;
		addr_paddr0 <= p0_r;
		addr_paddr1 <= p1_r;
		dram_ready <= ready_r;
		rd_data_valid <= valid_r;
		data_from_dram <= data_r;
	endtask

	initial
	begin
		reset = 1'b0;
		ssd_command_fifo_empty_or_not = 1'b1;
		ssd_command_fifo_out = '0;
		gc_command_fifo_empty_or_not = 1'b1;
		gc_command_fifo_out = '0;
		command_available = '1;
		dram_permit = 1'b0;
		dram_ready = 1'b0;
		rd_data_valid = 1'b0;
		data_from_dram = '0;
		addr_ack = 1'b0;
		addr_paddr0 = '0;
		addr_paddr1 = '0;
		load_stimulus();
		repeat (16) @(posedge clk);
		reset <= 1'b1;
		while (!finished)
		begin
			@(negedge clk);
			observe();
			@(posedge clk);
			drive_inputs();
		end
		if (completed == n_lines)
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
		else
		begin
			$display("Error at %0t: only %0d of %0d commands completed", $time, completed,
				n_lines);
			$display("SIMULATION FAILED");
			$fatal(1, "incomplete run");
		end
	end

endmodule

`default_nettype wire

// ==== sim/io_schedule_stimulus.txt ====
# src(0 host 1 gc) last(1 closes a group presented at once) command_available
# command paddr0 paddr1 expected_enable expected_controller_command
1 0 ff 0abcdef 5000011 0000400 20 80000000000000000000010001000011
0 1 ff 123456789b0000000000cafe00000123 2456789 0000000 04 123456789a4567890000cafe00000123
0 0 7f 6000000000000000000000030000beef 6abcdef 0000000 40 6000000000abcdef000000030000beef
1 1 7f 13000042 3000042 0000000 08 c0000000000000000000000003000042
1 1 fd 0000777 1000aaa 0123456 02 800000000000000000048d1581000aaa
0 1 ff 40000000000000000000001000001111 0123456 0000000 01 40000000001234560000001000001111
1 1 ff 17000005 7000005 0000000 80 c0000000000000000000000007000005
0 1 ff 0fedcba987654321000000000000abcd 4ffffff 0000000 10 0fedcba986ffffff000000000000abcd

// ==== io_schedule.f ====
hdl/io_schedule_pkg.sv
hdl/io_schedule_if.sv
hdl/sched_ctrl.sv
hdl/cmd_format.sv
hdl/chan_select.sv
hdl/addr_lookup.sv
hdl/wdata_fetch.sv
hdl/io_schedule.sv
sim/tb_io_schedule.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP ?= tb_io_schedule
FILELIST ?= io_schedule.f
SIM_BIN = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
